//--- hdl/iq_gain_pkg.sv
package iq_gain_pkg;

  // Cycles from an accepted input to a valid sum at the lane output
  localparam int LANE_LAT = 3;

  // Lane latency plus the combiner's output register
  localparam int PIPE_LAT = LANE_LAT + 1;

  // Per-item rounding choice when the sum drops back to sample format
  // ROUND_NEAREST rounds half up
  typedef enum logic {
    ROUND_TRUNC   = 1'b0,
    ROUND_NEAREST = 1'b1
  } round_mode_t;

endpackage : iq_gain_pkg

//--- hdl/iq_gain_top.sv
`timescale 1ns/1ps

module iq_gain_top #(
  parameter int SAMPLE_W = 16,
  parameter int SAMPLE_F = 15,
  parameter int GAIN_W   = 16,
  parameter int GAIN_F   = 14
) (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      in_valid,
  output logic                           in_ready,
  input  wire logic signed [SAMPLE_W-1:0] in_i,
  input  wire logic signed [SAMPLE_W-1:0] in_q,
  input  wire logic signed [GAIN_W-1:0]   gain,
  input  wire logic signed [SAMPLE_W-1:0] off_i,
  input  wire logic signed [SAMPLE_W-1:0] off_q,
  input  iq_gain_pkg::round_mode_t       round_mode,
  output logic                           out_valid,
  input  wire logic                      out_ready,
  output logic signed [SAMPLE_W-1:0]     out_i,
  output logic signed [SAMPLE_W-1:0]     out_q,
  output logic                           sat_i,
  output logic                           sat_q
);

  logic signed [SAMPLE_W+GAIN_W:0] sum_i;
  logic signed [SAMPLE_W+GAIN_W:0] sum_q;

  // in_ready doubles as the pipeline enable for both lanes
  multadd_lane #(
    .SAMPLE_W(SAMPLE_W),
    .SAMPLE_F(SAMPLE_F),
    .GAIN_W  (GAIN_W),
    .GAIN_F  (GAIN_F)
  ) lane_i (
    .clk    (clk),
    .rst    (rst),
    .advance(in_ready),
    .sample (in_i),
    .gain   (gain),
    .offset (off_i),
    .sum    (sum_i)
  );

  // Same gain word feeds both lanes
  multadd_lane #(
    .SAMPLE_W(SAMPLE_W),
    .SAMPLE_F(SAMPLE_F),
    .GAIN_W  (GAIN_W),
    .GAIN_F  (GAIN_F)
  ) lane_q (
    .clk    (clk),
    .rst    (rst),
    .advance(in_ready),
    .sample (in_q),
    .gain   (gain),
    .offset (off_q),
    .sum    (sum_q)
  );

  iq_round_sat #(
    .SAMPLE_W(SAMPLE_W),
    .SAMPLE_F(SAMPLE_F),
    .GAIN_W  (GAIN_W),
    .GAIN_F  (GAIN_F)
  ) round_sat_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .round_mode(round_mode),
    .sum_i     (sum_i),
    .sum_q     (sum_q),
    .out_ready (out_ready),
    .advance   (in_ready),
    .out_valid (out_valid),
    .out_i     (out_i),
    .out_q     (out_q),
    .sat_i     (sat_i),
    .sat_q     (sat_q)
  );

endmodule : iq_gain_top

//--- hdl/iq_round_sat.sv
`timescale 1ns/1ps

module iq_round_sat #(
  parameter int SAMPLE_W = 16,
  parameter int SAMPLE_F = 15,
  parameter int GAIN_W   = 16,
  parameter int GAIN_F   = 14
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            in_valid,
  input  iq_gain_pkg::round_mode_t             round_mode,
  input  wire logic signed [SAMPLE_W+GAIN_W:0] sum_i,
  input  wire logic signed [SAMPLE_W+GAIN_W:0] sum_q,
  input  wire logic                            out_ready,
  output logic                                 advance,
  output logic                                 out_valid,
  output logic signed [SAMPLE_W-1:0]           out_i,
  output logic signed [SAMPLE_W-1:0]           out_q,
  output logic                                 sat_i,
  output logic                                 sat_q
);

  localparam int SUM_W = SAMPLE_W + GAIN_W + 1;

  // Bits dropped to return from product fraction to sample fraction
  localparam int SUM_F = SAMPLE_F + GAIN_F;
  localparam int DROP  = SUM_F - SAMPLE_F;

  localparam logic signed [SUM_W-1:0] HALF_LSB = SUM_W'(1) << (DROP - 1);
  localparam logic signed [SUM_W-1:0] MAX_OUT  = SUM_W'(2 ** (SAMPLE_W - 1) - 1);
  localparam logic signed [SUM_W-1:0] MIN_OUT  = -MAX_OUT - 1;

  localparam int LANE_LAT = iq_gain_pkg::LANE_LAT;
  localparam int PIPE_LAT = iq_gain_pkg::PIPE_LAT;

  // Last entry of the valid pipe is the output stage itself
  logic [PIPE_LAT-1:0]      vld_pipe;
  iq_gain_pkg::round_mode_t mode_pipe [LANE_LAT];

  logic [SAMPLE_W:0] res_i;
  logic [SAMPLE_W:0] res_q;

  // Returns {saturated, value} for one lane
  function automatic logic [SAMPLE_W:0] round_sat(
    input logic signed [SUM_W-1:0] s,
    input iq_gain_pkg::round_mode_t mode
  );
    logic signed [SUM_W-1:0] biased;
    logic signed [SUM_W-1:0] shifted;
    biased  = (mode == iq_gain_pkg::ROUND_NEAREST) ? s + HALF_LSB : s;
    shifted = biased >>> DROP;
    if (shifted > MAX_OUT) begin
      return {1'b1, MAX_OUT[SAMPLE_W-1:0]};
    end else if (shifted < MIN_OUT) begin
      return {1'b1, MIN_OUT[SAMPLE_W-1:0]};
    end
    return {1'b0, shifted[SAMPLE_W-1:0]};
  endfunction

  // Whole pipeline moves unless the output holds an unaccepted item
  assign advance   = !out_valid || out_ready;
  assign out_valid = vld_pipe[PIPE_LAT-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else if (advance) begin
      vld_pipe <= {vld_pipe[PIPE_LAT-2:0], in_valid};
    end
  end

  // Mode rides along with its item through the lane stages
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < LANE_LAT; k++) begin
        mode_pipe[k] <= iq_gain_pkg::ROUND_TRUNC;
      end
    end else if (advance) begin
      mode_pipe[0] <= round_mode;
      for (int k = 1; k < LANE_LAT; k++) begin
        mode_pipe[k] <= mode_pipe[k-1];
      end
    end
  end

  assign res_i = round_sat(sum_i, mode_pipe[LANE_LAT-1]);
  assign res_q = round_sat(sum_q, mode_pipe[LANE_LAT-1]);

  // Output payload, held while stalled
  always_ff @(posedge clk) begin
    if (advance) begin
      out_i <= res_i[SAMPLE_W-1:0];
      out_q <= res_q[SAMPLE_W-1:0];
      sat_i <= res_i[SAMPLE_W];
      sat_q <= res_q[SAMPLE_W];
    end
  end

endmodule : iq_round_sat

//--- hdl/multadd_lane.sv
`timescale 1ns/1ps

module multadd_lane #(
  parameter int SAMPLE_W = 16,
  parameter int SAMPLE_F = 15,
  parameter int GAIN_W   = 16,
  parameter int GAIN_F   = 14
) (
  input  wire logic                                   clk,
  input  wire logic                                   rst,
  input  wire logic                                   advance,
  input  wire logic signed [SAMPLE_W-1:0]             sample,
  input  wire logic signed [GAIN_W-1:0]               gain,
  input  wire logic signed [SAMPLE_W-1:0]             offset,
  output logic signed [SAMPLE_W+GAIN_W:0]             sum
);

  // One extra bit over the product for the addition
  localparam int PROD_W = SAMPLE_W + GAIN_W;
  localparam int SUM_W  = PROD_W + 1;

  // Product carries SAMPLE_F + GAIN_F fraction bits while the offset has SAMPLE_F
  localparam int PROD_F = SAMPLE_F + GAIN_F;
  localparam int ALIGN  = PROD_F - SAMPLE_F;

  // Offset path is one entry per stage before the adder
  localparam int OFF_DEPTH = iq_gain_pkg::LANE_LAT - 1;
  localparam int OFF_LAST  = OFF_DEPTH - 1;

  logic signed [SAMPLE_W-1:0] sample_r;
  logic signed [GAIN_W-1:0]   gain_r;
  logic signed [SUM_W-1:0]    off_pipe [OFF_DEPTH];
  logic signed [PROD_W-1:0]   prod_r;
  logic signed [SUM_W-1:0]    sum_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      sample_r    <= '0;
      gain_r      <= '0;
      off_pipe[0] <= '0;
    end else if (advance) begin
      // Stage 1 captures the operands as accepted
      sample_r    <= sample;
      gain_r      <= gain;
      off_pipe[0] <= offset;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_r             <= '0;
      off_pipe[OFF_LAST] <= '0;
    end else if (advance) begin
      // Stage 2 full-precision product and binary point alignment
      prod_r             <= sample_r * gain_r;
      off_pipe[OFF_LAST] <= off_pipe[0] <<< ALIGN;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_r <= '0;
    end else if (advance) begin
      // Stage 3 add, sign extension of the product is implicit
      sum_r <= prod_r + off_pipe[OFF_LAST];
    end
  end

  assign sum = sum_r;

endmodule : multadd_lane

//--- project.f
+incdir+verification
hdl/iq_gain_pkg.sv
hdl/multadd_lane.sv
hdl/iq_round_sat.sv
hdl/iq_gain_top.sv
verification/iq_gain_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module iq_gain_tb -f project.f -o iq_gain_sim

# A failing run exits nonzero, the log decides the result
./obj_dir/iq_gain_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
  echo "run_sim: simulation passed"
  exit 0
fi

echo "run_sim: simulation failed"
exit 1

//--- verification/iq_gain_model.svh
`ifndef IQ_GAIN_MODEL_SVH
`define IQ_GAIN_MODEL_SVH

// Uses SAMPLE_W and GAIN_F from the including module

// Product and shifted offset both carry SAMPLE_F + GAIN_F fraction bits
function automatic longint model_sum(
  input longint sample,
  input longint gain_word,
  input longint offset
);
  return sample * gain_word + (offset <<< GAIN_F);
endfunction

// Drop GAIN_F bits, optionally adding half an output LSB first, then clamp
function automatic void model_round_sat(
  input  longint full,
  input  bit     nearest,
  output longint value,
  output bit     sat
);
  longint biased;
  longint max_v;
  longint min_v;
  max_v  = (longint'(1) <<< (SAMPLE_W - 1)) - 1;
  min_v  = -max_v - 1;
  biased = nearest ? full + (longint'(1) <<< (GAIN_F - 1)) : full;
  value  = biased >>> GAIN_F;
  sat    = 1'b0;
  if (value > max_v) begin
    value = max_v;
    sat   = 1'b1;
  end else if (value < min_v) begin
    value = min_v;
    sat   = 1'b1;
  end
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

`endif

//--- verification/iq_gain_tb.sv
`timescale 1ns/1ps

module iq_gain_tb;

  localparam int SAMPLE_W = 16;
  localparam int GAIN_W   = 16;
  localparam int GAIN_F   = 14;
  localparam int PIPE_LAT = iq_gain_pkg::PIPE_LAT;
  localparam int STREAM_ITEMS = 300;
  // Stream takes about four cycles per item with random stalls, plus the directed tests
  localparam int CYCLE_LIMIT = 5000;
  // Packed result {sat_i, out_i, sat_q, out_q}
  localparam int RES_W = 2 * SAMPLE_W + 2;

  `include "iq_gain_model.svh"

  logic                        clk;
  logic                        rst;
  logic                        in_valid;
  logic                        in_ready;
  logic signed [SAMPLE_W-1:0]  in_i;
  logic signed [SAMPLE_W-1:0]  in_q;
  logic signed [GAIN_W-1:0]    gain;
  logic signed [SAMPLE_W-1:0]  off_i;
  logic signed [SAMPLE_W-1:0]  off_q;
  iq_gain_pkg::round_mode_t    round_mode;
  logic                        out_valid;
  logic                        out_ready;
  logic signed [SAMPLE_W-1:0]  out_i;
  logic signed [SAMPLE_W-1:0]  out_q;
  logic                        sat_i;
  logic                        sat_q;

  logic [31:0] rng_state = 32'hac91b42a;
  int          cycle_count = 0;

  iq_gain_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_i      (in_i),
    .in_q      (in_q),
    .gain      (gain),
    .off_i     (off_i),
    .off_q     (off_q),
    .round_mode(round_mode),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_i     (out_i),
    .out_q     (out_q),
    .sat_i     (sat_i),
    .sat_q     (sat_q)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
      abort_run($sformatf("timeout, tests still running after %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [RES_W-1:0] expected_output(
    input logic signed [SAMPLE_W-1:0] si,
    input logic signed [SAMPLE_W-1:0] sq,
    input logic signed [GAIN_W-1:0]   g,
    input logic signed [SAMPLE_W-1:0] oi,
    input logic signed [SAMPLE_W-1:0] oq,
    input iq_gain_pkg::round_mode_t   mode
  );
    longint v_i;
    longint v_q;
    bit     s_i;
    bit     s_q;
    bit     nearest;
    nearest = (mode == iq_gain_pkg::ROUND_NEAREST);
    model_round_sat(model_sum(si, g, oi), nearest, v_i, s_i);
    model_round_sat(model_sum(sq, g, oq), nearest, v_q, s_q);
    return {s_i, v_i[SAMPLE_W-1:0], s_q, v_q[SAMPLE_W-1:0]};
  endfunction

  task automatic present_item(
    input logic signed [SAMPLE_W-1:0] si,
    input logic signed [SAMPLE_W-1:0] sq,
    input logic signed [GAIN_W-1:0]   g,
    input logic signed [SAMPLE_W-1:0] oi,
    input logic signed [SAMPLE_W-1:0] oq,
    input iq_gain_pkg::round_mode_t   mode
  );
    in_valid   = 1'b1;
    in_i       = si;
    in_q       = sq;
    gain       = g;
    off_i      = oi;
    off_q      = oq;
    round_mode = mode;
  endtask

  // One item through an empty pipeline, checks latency, value and no repeat
  task automatic send_single_item(
    input  logic signed [SAMPLE_W-1:0] si,
    input  logic signed [SAMPLE_W-1:0] sq,
    input  logic signed [GAIN_W-1:0]   g,
    input  logic signed [SAMPLE_W-1:0] oi,
    input  logic signed [SAMPLE_W-1:0] oq,
    input  iq_gain_pkg::round_mode_t   mode,
    output logic [RES_W-1:0]           result
  );
    logic [RES_W-1:0] want;
    int               latency;
    want = expected_output(si, sq, g, oi, oq, mode);
    @(posedge clk);
    #1;
    present_item(si, sq, g, oi, oq, mode);
    out_ready = 1'b1;
    @(negedge clk);
    assert (in_ready) else flag_mismatch("in_ready low with an empty pipeline");
    latency = 0;
    do begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      latency++;
      @(negedge clk);
    end while (!out_valid && latency < 4 * PIPE_LAT);
    assert (latency == PIPE_LAT)
      else flag_mismatch($sformatf("latency %0d cycles, expected %0d", latency, PIPE_LAT));
    result = {sat_i, out_i, sat_q, out_q};
    assert (result == want)
      else flag_mismatch($sformatf("result %h, expected %h", result, want));
    @(posedge clk);
    @(negedge clk);
    assert (!out_valid) else flag_mismatch("single item delivered twice");
  endtask

  task automatic idle_after_reset();
    int n;
    for (n = 0; n < 8; n++) begin
      @(posedge clk);
      #1;
      out_ready = n[0];
      @(negedge clk);
      assert (!out_valid && in_ready)
        else flag_mismatch("out_valid high or in_ready low while idle");
    end
  endtask

  task automatic single_item_latency();
    logic [RES_W-1:0] res;
    // 0.5 * 1.5 + 0.25 reaches 1.0 on I, Q stays in range
    send_single_item(16'sd16384, -16'sd8192, 16'sd24576, 16'sd8192, 16'sd4096,
                     iq_gain_pkg::ROUND_TRUNC, res);
    assert (res[RES_W-1] && res[RES_W-2:SAMPLE_W+1] == 16'h7fff && !res[SAMPLE_W])
      else flag_mismatch($sformatf("1.0 on I not clamped cleanly, got %h", res));
  endtask

  task automatic rounding_modes_differ();
    logic [RES_W-1:0] trunc_res;
    logic [RES_W-1:0] near_res;
    // +-3 times gain 0.5 leaves exactly half an LSB below the output
    send_single_item(16'sd3, -16'sd3, 16'sd8192, 16'sd0, 16'sd0,
                     iq_gain_pkg::ROUND_TRUNC, trunc_res);
    send_single_item(16'sd3, -16'sd3, 16'sd8192, 16'sd0, 16'sd0,
                     iq_gain_pkg::ROUND_NEAREST, near_res);
    assert (SAMPLE_W'(near_res[RES_W-2:SAMPLE_W+1] - trunc_res[RES_W-2:SAMPLE_W+1]) == 16'd1)
      else flag_mismatch("I lane rounding modes not one LSB apart");
    assert (SAMPLE_W'(near_res[SAMPLE_W-1:0] - trunc_res[SAMPLE_W-1:0]) == 16'd1)
      else flag_mismatch("Q lane rounding modes not one LSB apart");
  endtask

  task automatic saturation_both_ways();
    logic [RES_W-1:0] res;
    send_single_item(16'sd32767, 16'sd1000, 16'sd32767, 16'sd32767, 16'sd0,
                     iq_gain_pkg::ROUND_NEAREST, res);
    assert (res[RES_W-1] && res[RES_W-2:SAMPLE_W+1] == 16'h7fff && !res[SAMPLE_W])
      else flag_mismatch($sformatf("positive clamp on I wrong, got %h", res));
    send_single_item(16'sd1000, -16'sd32768, 16'sd32767, 16'sd0, -16'sd32768,
                     iq_gain_pkg::ROUND_TRUNC, res);
    assert (!res[RES_W-1] && res[SAMPLE_W] && res[SAMPLE_W-1:0] == 16'h8000)
      else flag_mismatch($sformatf("negative clamp on Q wrong, got %h", res));
  endtask

  task automatic random_stream_backpressure();
    logic [RES_W-1:0] expected[$];
    logic [RES_W-1:0] got;
    logic [RES_W-1:0] held;
    logic [RES_W-1:0] want;
    logic [31:0]      r;
    bit               stalled;
    bit               holding;
    int               sent;
    int               received;
    stalled  = 1'b0;
    holding  = 1'b0;
    sent     = 0;
    received = 0;
    while (received < STREAM_ITEMS) begin
      @(posedge clk);
      #1;
      // A presented item keeps its fields until accepted
      if (!holding) begin
        r = next_rand();
        if (sent < STREAM_ITEMS && r[1:0] != 2'b00) begin
          in_valid = 1'b1;
          in_i     = r[15:0];
          in_q     = r[31:16];
          r        = next_rand();
          gain     = r[15:0];
          off_i    = r[31:16];
          r        = next_rand();
          off_q    = r[15:0];
          round_mode = iq_gain_pkg::round_mode_t'(r[16]);
        end else begin
          in_valid = 1'b0;
        end
      end
      r = next_rand();
      out_ready = (r[3:0] > 4'd5);
      @(negedge clk);
      got = {sat_i, out_i, sat_q, out_q};
      if (stalled) begin
        assert (out_valid && got == held)
          else flag_mismatch($sformatf("output moved during stall, %h became %h", held, got));
      end
      if (out_valid && !out_ready) begin
        assert (!in_ready) else flag_mismatch("in_ready high while the output is stalled");
      end
      if (in_valid && in_ready) begin
        expected.push_back(expected_output(in_i, in_q, gain, off_i, off_q, round_mode));
        sent++;
        holding = 1'b0;
      end else begin
        holding = in_valid;
      end
      if (out_valid && out_ready) begin
        assert (expected.size() != 0)
          else abort_run("output delivered with no item outstanding");
        want = expected.pop_front();
        assert (got == want)
          else flag_mismatch($sformatf("item %0d is %h, expected %h", received, got, want));
        received++;
      end
      stalled = out_valid && !out_ready;
      held    = got;
    end
    @(posedge clk);
    #1;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    // Nothing may follow the last item
    repeat (PIPE_LAT + 1) begin
      @(negedge clk);
      assert (!out_valid) else flag_mismatch("extra item delivered after the stream");
    end
  endtask

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_i       = '0;
    in_q       = '0;
    gain       = '0;
    off_i      = '0;
    off_q      = '0;
    round_mode = iq_gain_pkg::ROUND_TRUNC;
    out_ready  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    idle_after_reset();
    single_item_latency();
    rounding_modes_differ();
    saturation_both_ways();
    random_stream_backpressure();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : iq_gain_tb
